// ==== src/fc_pkg.sv ====
// Float word format and layer sizes shared by every RTL file of the layer, imported by wildcard
package fc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Float word format
  //////////////////////////////////////////////////////////////////////

  localparam int WORD_W = 32;
  localparam int EXP_W = 8;
  localparam int MAN_W = 23;
  localparam int EXP_BIAS = 127;

  // Largest exponent kept when a result overflows
  localparam int EXP_MAX = 254;

  //////////////////////////////////////////////////////////////////////
  // Layer size
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_NEURONS = 6;
  localparam int TAP_BUS_W = NUM_NEURONS * WORD_W;

  // One data word, seen either as raw bits or as float fields
  typedef union packed {
    logic [WORD_W-1:0] bits;
    struct packed {
      logic             sgn;
      logic [EXP_W-1:0] exp;
      logic [MAN_W-1:0] man;
    } f;
  } float_word_t;

endpackage

// ==== src/float_mul.sv ====
// Combinational float multiplier with truncation and saturation, one per neuron
`timescale 1ns/1ps

module float_mul (
  input  fc_pkg::float_word_t a,
  input  fc_pkg::float_word_t b,
  output fc_pkg::float_word_t p
);

  import fc_pkg::*;

  logic                      either_zero;
  logic                      sgn;
  logic [MAN_W:0]            man_a;
  logic [MAN_W:0]            man_b;
  logic [2*MAN_W+1:0]        prod;
  logic                      norm;
  logic [MAN_W-1:0]          man_res;
  logic signed [EXP_W+1:0]   exp_sum;

  // Exponent zero means the operand is zero
  assign either_zero = (a.f.exp == '0) || (b.f.exp == '0);
  assign sgn = a.f.sgn ^ b.f.sgn;

  // Hidden bits restored before the multiply
  assign man_a = {1'b1, a.f.man};
  assign man_b = {1'b1, b.f.man};
  assign prod = man_a * man_b;

  // Product lies in [1,4), so at most one bit of normalization
  assign norm = prod[2*MAN_W+1];
  assign man_res = norm ? prod[2*MAN_W:MAN_W+1] : prod[2*MAN_W-1:MAN_W];

  // Two extra bits keep the biased sum and its sign
  assign exp_sum = {2'b00, a.f.exp} + {2'b00, b.f.exp} + {{(EXP_W+1){1'b0}}, norm}
                 - (EXP_W+2)'(EXP_BIAS);

  always_comb begin
    p.bits = '0;
    if (either_zero) begin
      p.bits = '0;
    end else if (exp_sum <= 0) begin
      // Underflow flushes to the zero word
      p.bits = '0;
    end else if (exp_sum > EXP_MAX) begin
      p.f.sgn = sgn;
      p.f.exp = EXP_W'(EXP_MAX);
      p.f.man = '1;
    end else begin
      p.f.sgn = sgn;
      p.f.exp = exp_sum[EXP_W-1:0];
      p.f.man = man_res;
    end
  end

endmodule

// ==== src/float_add.sv ====
// Combinational float adder with alignment, truncation and renormalization, one per neuron
`timescale 1ns/1ps

module float_add (
  input  fc_pkg::float_word_t a,
  input  fc_pkg::float_word_t b,
  output fc_pkg::float_word_t s
);

  import fc_pkg::*;

  logic                      a_zero;
  logic                      b_zero;
  logic                      swap;
  logic                      same_sgn;
  float_word_t               big;
  float_word_t               lesser;
  logic [EXP_W-1:0]          exp_diff;
  logic [MAN_W:0]            man_big;
  logic [MAN_W:0]            man_small;
  logic [MAN_W+1:0]          sum_ext;
  logic [EXP_W+1:0]          exp_inc;
  logic [MAN_W:0]            dif;
  logic [4:0]                lz;
  logic [MAN_W:0]            dif_norm;
  logic signed [EXP_W+1:0]   exp_norm;

  assign a_zero = (a.f.exp == '0);
  assign b_zero = (b.f.exp == '0);

  //////////////////////////////////////////////////////////////////////
  // Magnitude ordering and alignment
  //////////////////////////////////////////////////////////////////////

  assign swap = (b.f.exp > a.f.exp) || ((b.f.exp == a.f.exp) && (b.f.man > a.f.man));
  assign big = swap ? b : a;
  assign lesser = swap ? a : b;
  assign same_sgn = (a.f.sgn == b.f.sgn);

  assign exp_diff = big.f.exp - lesser.f.exp;
  assign man_big = {1'b1, big.f.man};

  // Shift past the whole mantissa leaves nothing
  assign man_small = (exp_diff >= EXP_W'(MAN_W + 1)) ? '0
                   : ({1'b1, lesser.f.man} >> exp_diff);

  //////////////////////////////////////////////////////////////////////
  // Add path
  //////////////////////////////////////////////////////////////////////

  assign sum_ext = {1'b0, man_big} + {1'b0, man_small};
  assign exp_inc = {2'b00, big.f.exp} + (EXP_W+2)'(1);

  //////////////////////////////////////////////////////////////////////
  // Subtract path
  //////////////////////////////////////////////////////////////////////

  // Big mantissa is never below the aligned small one
  assign dif = man_big - man_small;

  // Leading zeros above the highest set bit
  always_comb begin
    lz = '0;
    for (int i = 0; i <= MAN_W; i++) begin
      if (dif[i]) begin
        lz = 5'(MAN_W - i);
      end
    end
  end

  assign dif_norm = dif << lz;
  assign exp_norm = {2'b00, big.f.exp} - {{(EXP_W-3){1'b0}}, lz};

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    s.bits = '0;
    if (a_zero && b_zero) begin
      s.bits = '0;
    end else if (a_zero) begin
      s = b;
    end else if (b_zero) begin
      s = a;
    end else if (same_sgn) begin
      s.f.sgn = big.f.sgn;
      if (sum_ext[MAN_W+1]) begin
        // Carry out, renormalize one place
        if (exp_inc > EXP_MAX) begin
          s.f.exp = EXP_W'(EXP_MAX);
          s.f.man = '1;
        end else begin
          s.f.exp = exp_inc[EXP_W-1:0];
          s.f.man = sum_ext[MAN_W:1];
        end
      end else begin
        s.f.exp = big.f.exp;
        s.f.man = sum_ext[MAN_W-1:0];
      end
    end else if ((dif != '0) && (exp_norm > 0)) begin
      s.f.sgn = big.f.sgn;
      s.f.exp = exp_norm[EXP_W-1:0];
      s.f.man = dif_norm[MAN_W-1:0];
    end
    // Cancellation and underflow fall through to the zero word
  end

  // Only the zero word may carry a zero exponent
  always_comb begin
    assert final ((s.bits == '0) || (s.f.exp != '0))
      else $error("float_add returned a nonzero word with a zero exponent");
  end

endmodule

// ==== src/neuron_mac.sv ====
// Single neuron that multiplies the shared data by its tap and accumulates per vector
`timescale 1ns/1ps

module neuron_mac (
  input  logic                clk,
  input  logic                reset,
  input  logic                first,
  input  fc_pkg::float_word_t data,
  input  fc_pkg::float_word_t tap,
  output fc_pkg::float_word_t acc
);

  import fc_pkg::*;

  float_word_t prod;
  float_word_t acc_in;
  float_word_t acc_next;

  float_mul u_mul (
    .a (data),
    .b (tap),
    .p (prod)
  );

  // New vector starts from the zero word
  assign acc_in.bits = first ? '0 : acc.bits;

  float_add u_add (
    .a (acc_in),
    .b (prod),
    .s (acc_next)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      acc.bits <= '0;
    end else begin
      acc <= acc_next;
    end
  end

  // Accumulator must stay known once out of reset
  assert property (@(posedge clk) disable iff (reset) !$isunknown(acc.bits))
    else $error("neuron_mac accumulator went unknown");

endmodule

// ==== src/result_line.sv ====
// Output delay line that captures all neuron sums on first and shifts them out one per cycle
`timescale 1ns/1ps

module result_line (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          first,
  input  logic [fc_pkg::TAP_BUS_W-1:0]  sums,
  output fc_pkg::float_word_t           data_out_pre
);

  import fc_pkg::*;

  float_word_t slot [NUM_NEURONS];

  // Parallel load on first, else shift toward slot 0 with the last slot holding
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_NEURONS; i++) begin
        slot[i].bits <= '0;
      end
    end else if (first) begin
      for (int i = 0; i < NUM_NEURONS; i++) begin
        slot[i].bits <= sums[i*WORD_W +: WORD_W];
      end
    end else begin
      for (int i = 0; i < NUM_NEURONS - 1; i++) begin
        slot[i] <= slot[i+1];
      end
    end
  end

  assign data_out_pre = slot[0];

endmodule

// ==== src/fc_layer.sv ====
// Top level of the six-neuron fully connected layer with serial and parallel result outputs
`timescale 1ns/1ps

module fc_layer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          first,
  input  fc_pkg::float_word_t           data,
  input  logic [fc_pkg::TAP_BUS_W-1:0]  taps,
  output logic [fc_pkg::TAP_BUS_W-1:0]  tap_out,
  output fc_pkg::float_word_t           data_out_pre
);

  import fc_pkg::*;

  // All accumulators side by side, neuron i in word i
  logic [TAP_BUS_W-1:0] sums;

  //////////////////////////////////////////////////////////////////////
  // Neurons
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_NEURONS; i++) begin : g_neuron
    float_word_t tap_w;
    float_word_t acc_w;

    assign tap_w.bits = taps[i*WORD_W +: WORD_W];

    neuron_mac u_neuron (
      .clk   (clk),
      .reset (reset),
      .first (first),
      .data  (data),
      .tap   (tap_w),
      .acc   (acc_w)
    );

    assign sums[i*WORD_W +: WORD_W] = acc_w.bits;
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  // Finished sums leave serially after each first
  result_line u_result_line (
    .clk          (clk),
    .reset        (reset),
    .first        (first),
    .sums         (sums),
    .data_out_pre (data_out_pre)
  );

  // Parallel view of the accumulators, one cycle late
  always_ff @(posedge clk) begin
    if (reset) begin
      tap_out <= '0;
    end else begin
      tap_out <= sums;
    end
  end

endmodule

// ==== bench/fc_layer_checker.sv ====
// Reference model of the layer that watches the DUT ports and compares its outputs every cycle
`timescale 1ns/1ps

module fc_layer_checker (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          first,
  input  logic [fc_pkg::WORD_W-1:0]     data,
  input  logic [fc_pkg::TAP_BUS_W-1:0]  taps,
  input  logic [fc_pkg::TAP_BUS_W-1:0]  tap_out,
  input  logic [fc_pkg::WORD_W-1:0]     data_out_pre,
  output int                            error_count,
  output int                            check_count
);

  import fc_pkg::*;

  // Exponent bias and the largest exponent kept on overflow
  localparam int BIAS = 127;
  localparam int SAT_EXP = 254;

  logic [WORD_W-1:0] acc_m [NUM_NEURONS];
  logic [WORD_W-1:0] tap_m [NUM_NEURONS];
  logic [WORD_W-1:0] slot_m [NUM_NEURONS];
  logic              armed = 1'b0;
  int                errors = 0;
  int                checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  //////////////////////////////////////////////////////////////////////
  // Float arithmetic model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [WORD_W-1:0] model_mul(input logic [WORD_W-1:0] x,
                                                  input logic [WORD_W-1:0] y);
    logic [2*MAN_W+1:0] prod;
    logic [MAN_W-1:0]   m;
    logic               sgn;
    int                 e;
    if ((x[WORD_W-2:MAN_W] == 0) || (y[WORD_W-2:MAN_W] == 0)) begin
      return '0;
    end
    sgn = x[WORD_W-1] ^ y[WORD_W-1];
    prod = {1'b1, x[MAN_W-1:0]} * {1'b1, y[MAN_W-1:0]};
    e = int'(x[WORD_W-2:MAN_W]) + int'(y[WORD_W-2:MAN_W]) - BIAS;
    if (prod[2*MAN_W+1]) begin
      m = prod[2*MAN_W:MAN_W+1];
      e = e + 1;
    end else begin
      m = prod[2*MAN_W-1:MAN_W];
    end
    if (e <= 0) begin
      return '0;
    end
    if (e > SAT_EXP) begin
      return {sgn, EXP_W'(SAT_EXP), {MAN_W{1'b1}}};
    end
    return {sgn, e[EXP_W-1:0], m};
  endfunction

  function automatic logic [WORD_W-1:0] model_add(input logic [WORD_W-1:0] x,
                                                  input logic [WORD_W-1:0] y);
    logic [WORD_W-1:0] hi;
    logic [WORD_W-1:0] lo;
    logic [MAN_W:0]    mhi;
    logic [MAN_W:0]    mlo;
    logic [MAN_W+1:0]  total;
    int                ehi;
    int                shift;
    if ((x[WORD_W-2:MAN_W] == 0) && (y[WORD_W-2:MAN_W] == 0)) begin
      return '0;
    end
    if (x[WORD_W-2:MAN_W] == 0) begin
      return y;
    end
    if (y[WORD_W-2:MAN_W] == 0) begin
      return x;
    end
    // Exponent above mantissa, so the low 31 bits order by magnitude
    if (y[WORD_W-2:0] > x[WORD_W-2:0]) begin
      hi = y;
      lo = x;
    end else begin
      hi = x;
      lo = y;
    end
    ehi = int'(hi[WORD_W-2:MAN_W]);
    shift = ehi - int'(lo[WORD_W-2:MAN_W]);
    mhi = {1'b1, hi[MAN_W-1:0]};
    mlo = (shift > MAN_W) ? '0 : ({1'b1, lo[MAN_W-1:0]} >> shift);
    if (hi[WORD_W-1] == lo[WORD_W-1]) begin
      total = mhi + mlo;
      if (!total[MAN_W+1]) begin
        return {hi[WORD_W-1], hi[WORD_W-2:MAN_W], total[MAN_W-1:0]};
      end
      ehi = ehi + 1;
      if (ehi > SAT_EXP) begin
        return {hi[WORD_W-1], EXP_W'(SAT_EXP), {MAN_W{1'b1}}};
      end
      return {hi[WORD_W-1], ehi[EXP_W-1:0], total[MAN_W:1]};
    end
    mhi = mhi - mlo;
    if (mhi == 0) begin
      return '0;
    end
    while (!mhi[MAN_W]) begin
      mhi = mhi << 1;
      ehi = ehi - 1;
    end
    if (ehi <= 0) begin
      return '0;
    end
    return {hi[WORD_W-1], ehi[EXP_W-1:0], mhi[MAN_W-1:0]};
  endfunction

  task automatic compare_word(input string name, input logic [WORD_W-1:0] expected,
                              input logic [WORD_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare, then advance the model
  //////////////////////////////////////////////////////////////////////

  // Outputs read here still hold their values from before this edge
  always @(posedge clk) begin : model_step
    logic [WORD_W-1:0] next_acc [NUM_NEURONS];
    if (armed) begin
      for (int i = 0; i < NUM_NEURONS; i++) begin
        compare_word($sformatf("tap_out[%0d]", i), tap_m[i], tap_out[i*WORD_W +: WORD_W]);
      end
      compare_word("data_out_pre", slot_m[0], data_out_pre);
    end
    if (reset) begin
      for (int i = 0; i < NUM_NEURONS; i++) begin
        acc_m[i] = '0;
        tap_m[i] = '0;
        slot_m[i] = '0;
      end
      armed = 1'b1;
    end else begin
      for (int i = 0; i < NUM_NEURONS; i++) begin
        next_acc[i] = model_add(first ? {WORD_W{1'b0}} : acc_m[i],
                                model_mul(data, taps[i*WORD_W +: WORD_W]));
        tap_m[i] = acc_m[i];
      end
      if (first) begin
        for (int i = 0; i < NUM_NEURONS; i++) begin
          slot_m[i] = acc_m[i];
        end
      end else begin
        for (int i = 0; i < NUM_NEURONS - 1; i++) begin
          slot_m[i] = slot_m[i+1];
        end
      end
      for (int i = 0; i < NUM_NEURONS; i++) begin
        acc_m[i] = next_acc[i];
      end
    end
  end

endmodule

// ==== bench/fc_layer_tb.sv ====
// Testbench top for the fully connected layer, run through tb.f with the checker alongside
`timescale 1ns/1ps

module fc_layer_tb;

  import fc_pkg::*;

  localparam int NUM_VECTORS = 40;
  localparam int MAX_LEN = 10;
  localparam int CYCLE_LIMIT = NUM_VECTORS * MAX_LEN + 40;

  logic                 clk;
  logic                 reset;
  logic                 first;
  logic [WORD_W-1:0]    data;
  logic [TAP_BUS_W-1:0] taps;
  logic [TAP_BUS_W-1:0] tap_out;
  logic [WORD_W-1:0]    data_out_pre;
  int                   error_count;
  int                   check_count;
  int                   cycle_count = 0;
  logic [31:0]          lfsr_state = 32'he8749396;

  fc_layer dut (
    .clk          (clk),
    .reset        (reset),
    .first        (first),
    .data         (data),
    .taps         (taps),
    .tap_out      (tap_out),
    .data_out_pre (data_out_pre)
  );

  fc_layer_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .first        (first),
    .data         (data),
    .taps         (taps),
    .tap_out      (tap_out),
    .data_out_pre (data_out_pre),
    .error_count  (error_count),
    .check_count  (check_count)
  );

  //////////////////////////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////////////////////////

  // Taps at 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Roughly one word in eight is zero, exponents stay near the bias
  function automatic logic [WORD_W-1:0] random_word();
    logic             sgn;
    logic [EXP_W-1:0] e;
    logic [MAN_W-1:0] m;
    if (take_bits(3) == 0) begin
      return '0;
    end
    sgn = (take_bits(1) != 0);
    e = EXP_W'(120 + take_bits(4) % 15);
    m = MAN_W'(take_bits(MAN_W));
    return {sgn, e, m};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Clock, stimulus and timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    int                   len;
    logic [WORD_W-1:0]    prev_data;
    logic [TAP_BUS_W-1:0] prev_taps;
    reset = 1'b1;
    first = 1'b0;
    data = '0;
    taps = '0;
    prev_data = '0;
    prev_taps = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int v = 0; v < NUM_VECTORS; v++) begin
      len = 6 + int'(take_bits(3) % 5);
      for (int e = 0; e < len; e++) begin
        @(negedge clk);
        first = (e == 0);
        if ((e == 1) && (take_bits(2) == 0)) begin
          // Negated copy of the first element cancels the sum exactly
          data = prev_data ^ {1'b1, {(WORD_W-1){1'b0}}};
          taps = prev_taps;
        end else begin
          data = random_word();
          for (int n = 0; n < NUM_NEURONS; n++) begin
            taps[n*WORD_W +: WORD_W] = random_word();
          end
        end
        prev_data = data;
        prev_taps = taps;
      end
    end
    // Last strobe loads the final vector for readout
    @(negedge clk);
    first = 1'b1;
    data = '0;
    taps = '0;
    @(negedge clk);
    first = 1'b0;
    repeat (8) @(negedge clk);
    $display("Closing report: %0d checks, %0d errors", check_count, error_count);
    if ((error_count == 0) && (check_count > 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Closing report: %0d checks, %0d errors", check_count, error_count);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
src/fc_pkg.sv
src/float_mul.sv
src/float_add.sv
src/neuron_mac.sv
src/result_line.sv
src/fc_layer.sv
bench/fc_layer_checker.sv
bench/fc_layer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fully connected layer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=fc_layer_tb
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

echo "Building ${TOP}"
if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module "${TOP}" --Mdir "${OBJ_DIR}" -f tb.f; then
  echo "Verilator build failed"
  exit 1
fi

echo "Running simulation"
if ! "./${OBJ_DIR}/V${TOP}" > "${LOG}" 2>&1; then
  cat "${LOG}"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "${LOG}"

if grep -qx "TEST PASS" "${LOG}"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see ${LOG}"
  exit 1
fi
